//--- design/exerion_pkg.sv
// exerion video core definitions
package exerion_pkg;

	// ==================================================
	// types
	// ==================================================
	typedef logic [8:0]  pix_h_t;      // horizontal count, 88..511
	typedef logic [7:0]  pix_v_t;      // vertical count, full 8 bit wrap
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  color_idx_t;  // zero is transparent
	typedef logic [4:0]  pal_addr_t;   // 32 entry colour prom
	typedef logic [15:0] dn_addr_t;
	typedef logic [10:0] vram_addr_t;

	// colour prom byte as it leaves the board
	typedef struct packed {
		logic [1:0] blue;
		logic [2:0] green;
		logic [2:0] red;
	} rgb_t;

	// ==================================================
	// raster
	// ==================================================
	localparam pix_h_t H_FIRST   = 9'd88;
	localparam pix_h_t H_LAST    = 9'd511;
	localparam pix_h_t HBLANK_LO = 9'd107;   // first visible pixel
	localparam pix_h_t HBLANK_HI = 9'd428;   // last visible pixel
	localparam pix_v_t VBLANK_LO = 8'd16;
	localparam pix_v_t VBLANK_HI = 8'd239;
	localparam pix_h_t HSYNC_LO  = 9'd464;
	localparam pix_h_t HSYNC_HI  = 9'd479;
	localparam pix_v_t VSYNC_LO  = 8'd248;
	localparam pix_v_t VSYNC_HI  = 8'd251;
	localparam int     PIX_LAT   = 5;        // counters to rgb
	localparam int     FG_LAT    = 3;        // counters to fg index

	// ==================================================
	// cpu address map, 2k pages
	// ==================================================
	localparam int        PAGE_LSB  = 11;
	localparam cpu_addr_t VRAM_BASE = 16'h8000;
	localparam cpu_addr_t IN1_ADDR  = 16'hA000;  // controls
	localparam cpu_addr_t IN2_ADDR  = 16'hA800;  // dip 1
	localparam cpu_addr_t IN3_ADDR  = 16'hB000;  // status
	localparam cpu_addr_t CTRL_ADDR = 16'hC000;

	// download windows
	localparam dn_addr_t DN_CHAR_BASE    = 16'h0000;
	localparam int       DN_CHAR_SIZE    = 8192;
	localparam dn_addr_t DN_FGPROM_BASE  = 16'h2000;
	localparam int       DN_FGPROM_SIZE  = 256;   // low nibble used
	localparam dn_addr_t DN_COLPROM_BASE = 16'h2100;
	localparam int       DN_COLPROM_SIZE = 32;

	// c000 latch bits
	localparam int CTRL_FLIP      = 0;
	localparam int CTRL_PAL_A6    = 1;
	localparam int CTRL_PAL_A7    = 2;
	localparam int CTRL_CHAR_BANK = 3;
	localparam int CTRL_W         = 4;

endpackage

//--- design/video_timing.sv
// raster timing generator
`timescale 1ns/1ps

module video_timing (
	input  logic                clk2_6MHZ,
	input  logic                RAMB,
	input  logic                flip_i,
	output exerion_pkg::pix_h_t flip_h_o,
	output exerion_pkg::pix_v_t flip_v_o,
	output logic                vblank_raw_o,
	output logic                hblank_s3_o,
	output logic                vblank_s3_o,
	output logic                hsync_o,
	output logic                vsync_o,
	output logic                hblank_o,
	output logic                vblank_o
);
	import exerion_pkg::*;

	pix_h_t             h_cnt;
	pix_v_t             v_cnt;
	logic               hsync_raw;
	logic               vsync_raw;
	logic               hblank_raw;
	logic [PIX_LAT-1:0] hs_dly;
	logic [PIX_LAT-1:0] vs_dly;
	logic [PIX_LAT-1:0] hb_dly;
	logic [PIX_LAT-1:0] vb_dly;

	// 424 clocks per line, 256 lines
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			h_cnt <= H_FIRST;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= H_FIRST;
			v_cnt <= v_cnt + 8'd1;   // wraps on its own
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	assign hblank_raw   = (h_cnt < HBLANK_LO) || (h_cnt > HBLANK_HI);
	assign vblank_raw_o = (v_cnt < VBLANK_LO) || (v_cnt > VBLANK_HI);
	assign hsync_raw    = (h_cnt >= HSYNC_LO) && (h_cnt <= HSYNC_HI);
	assign vsync_raw    = !((v_cnt >= VSYNC_LO) && (v_cnt <= VSYNC_HI));  // active low

	// cocktail flip inverts both counts
	assign flip_h_o = flip_i ? ~h_cnt : h_cnt;
	assign flip_v_o = flip_i ? ~v_cnt : v_cnt;

	// ==================================================
	// align raster outputs with the pixel pipe
	// ==================================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			hs_dly <= '0;
			vs_dly <= '1;
			hb_dly <= '1;
			vb_dly <= '1;
		end else begin
			hs_dly <= {hs_dly[PIX_LAT-2:0], hsync_raw};
			vs_dly <= {vs_dly[PIX_LAT-2:0], vsync_raw};
			hb_dly <= {hb_dly[PIX_LAT-2:0], hblank_raw};
			vb_dly <= {vb_dly[PIX_LAT-2:0], vblank_raw_o};
		end
	end

	assign hsync_o     = hs_dly[PIX_LAT-1];
	assign vsync_o     = vs_dly[PIX_LAT-1];
	assign hblank_o    = hb_dly[PIX_LAT-1];
	assign vblank_o    = vb_dly[PIX_LAT-1];
	assign hblank_s3_o = hb_dly[FG_LAT-1];   // tap seen by the mixer
	assign vblank_s3_o = vb_dly[FG_LAT-1];

	h_floor: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB) h_cnt >= H_FIRST)
		else $error("horizontal count left the 88..511 range");

endmodule

//--- design/cpu_bus_port.sv
// cpu bus decode and control latch
`timescale 1ns/1ps

module cpu_bus_port (
	input  logic                    clk2_6MHZ,
	input  logic                    RAMB,
	input  exerion_pkg::cpu_addr_t  bus_addr_i,
	input  exerion_pkg::byte_t      bus_wdata_i,
	input  logic                    bus_wr_i,
	input  logic                    bus_rd_i,
	input  exerion_pkg::byte_t      controls_i,
	input  exerion_pkg::byte_t      dip1_i,
	input  exerion_pkg::byte_t      dip2_i,
	input  logic                    vblank_i,
	input  exerion_pkg::byte_t      vram_q_i,
	output exerion_pkg::byte_t      bus_rdata_o,
	output logic                    vram_cs_o,
	output logic                    vram_we_o,
	output exerion_pkg::vram_addr_t vram_addr_o,
	output exerion_pkg::byte_t      vram_wdata_o,
	output logic                    flip_o,
	output logic                    pal_a6_o,
	output logic                    pal_a7_o,
	output logic                    char_bank_o
);
	import exerion_pkg::*;

	logic [15:PAGE_LSB] page;
	logic               vram_hit;
	logic               ctrl_we;
	byte_t              port_data;
	logic [CTRL_W-1:0]  ctrl_q;
	logic               rd_q;        // read in flight
	logic               rd_vram_q;   // ... and it targets vram
	byte_t              port_q;

	assign page     = bus_addr_i[15:PAGE_LSB];
	assign vram_hit = (page == VRAM_BASE[15:PAGE_LSB]);
	assign ctrl_we  = bus_wr_i && (page == CTRL_ADDR[15:PAGE_LSB]);

	// vram steals the tile port for this cycle
	assign vram_cs_o    = vram_hit && (bus_wr_i || bus_rd_i);
	assign vram_we_o    = vram_hit && bus_wr_i;
	assign vram_addr_o  = bus_addr_i[PAGE_LSB-1:0];
	assign vram_wdata_o = bus_wdata_i;

	// input ports, unmapped pages read back 0
	always_comb begin
		port_data = '0;
		if (page == IN1_ADDR[15:PAGE_LSB])
			port_data = controls_i;
		else if (page == IN2_ADDR[15:PAGE_LSB])
			port_data = dip1_i;
		else if (page == IN3_ADDR[15:PAGE_LSB])
			port_data = {4'b0000, dip2_i[1], dip2_i[0], dip2_i[2], vblank_i};
	end

	// c000 latch
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB)
			ctrl_q <= '0;
		else if (ctrl_we)
			ctrl_q <= bus_wdata_i[CTRL_W-1:0];
	end

	assign flip_o      = ctrl_q[CTRL_FLIP];
	assign pal_a6_o    = ctrl_q[CTRL_PAL_A6];
	assign pal_a7_o    = ctrl_q[CTRL_PAL_A7];
	assign char_bank_o = ctrl_q[CTRL_CHAR_BANK];

	// ==================================================
	// read path, step one samples, step two returns
	// ==================================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			rd_q        <= 1'b0;
			rd_vram_q   <= 1'b0;
			bus_rdata_o <= '0;
		end else begin
			rd_q      <= bus_rd_i;
			rd_vram_q <= vram_hit;
			if (rd_q)
				bus_rdata_o <= rd_vram_q ? vram_q_i : port_q;   // held until next read
		end
	end

	always_ff @(posedge clk2_6MHZ) begin
		if (bus_rd_i)
			port_q <= port_data;   // vblank captured at the strobe
	end

	rd_wr_excl: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		!(bus_rd_i && bus_wr_i))
		else $error("bus read and write strobes high together");

endmodule

//--- design/rom_table.sv
// downloadable lookup rom
`timescale 1ns/1ps

module rom_table #(
	parameter exerion_pkg::dn_addr_t BASE  = 16'h0000,
	parameter int                    DEPTH = 256
) (
	input  logic                     clk2_6MHZ,
	input  exerion_pkg::dn_addr_t    dn_addr_i,
	input  exerion_pkg::byte_t       dn_data_i,
	input  logic                     dn_wr_i,
	input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
	output exerion_pkg::byte_t       q_o
);
	import exerion_pkg::*;

	localparam int AW = $clog2(DEPTH);

	byte_t    mem [DEPTH];
	dn_addr_t dn_off;
	logic     dn_hit;

	// own window of the download space
	assign dn_off = dn_addr_i - BASE;
	assign dn_hit = dn_wr_i && (dn_addr_i >= BASE) && (int'(dn_off) < DEPTH);

	always_ff @(posedge clk2_6MHZ) begin
		if (dn_hit)
			mem[dn_off[AW-1:0]] <= dn_data_i;
		q_o <= mem[rd_addr_i];   // registered read, one clock
	end

endmodule

//--- design/tile_layer.sv
// foreground character layer
`timescale 1ns/1ps

module tile_layer (
	input  logic                     clk2_6MHZ,
	input  logic                     RAMB,
	input  exerion_pkg::pix_h_t      flip_h_i,
	input  exerion_pkg::pix_v_t      flip_v_i,
	input  logic                     vram_cs_i,
	input  logic                     vram_we_i,
	input  exerion_pkg::vram_addr_t  vram_addr_i,
	input  exerion_pkg::byte_t       vram_wdata_i,
	input  logic                     pal_a6_i,
	input  logic                     pal_a7_i,
	input  logic                     char_bank_i,
	input  exerion_pkg::dn_addr_t    dn_addr_i,
	input  exerion_pkg::byte_t       dn_data_i,
	input  logic                     dn_wr_i,
	output exerion_pkg::byte_t       vram_q_o,
	output exerion_pkg::color_idx_t  fg_idx_o
);
	import exerion_pkg::*;

	byte_t      vram [2**PAGE_LSB];
	vram_addr_t vram_addr;
	logic [2:0] row_s1;        // pixel row in tile
	logic [2:0] hlo_s1;
	logic [3:0] code_hi_s2;    // attribute nibble for the prom
	logic [1:0] col_s2;
	logic [12:0] char_addr;
	byte_t      char_q;
	logic [1:0] pix;
	logic [7:0] fg_addr;
	byte_t      fg_q;

	// ==================================================
	// stage 1, vram
	// ==================================================
	// cpu wins the port when it strobes, raster glitch is tolerated
	assign vram_addr = vram_cs_i ? vram_addr_i : {flip_v_i[7:3], flip_h_i[8:3]};

	always_ff @(posedge clk2_6MHZ) begin
		if (vram_cs_i && vram_we_i)
			vram[vram_addr] <= vram_wdata_i;
		vram_q_o <= vram[vram_addr];   // shared with cpu reads
	end

	// low count bits ride along with the fetch
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			row_s1     <= '0;
			hlo_s1     <= '0;
			code_hi_s2 <= '0;
			col_s2     <= '0;
		end else begin
			row_s1     <= flip_v_i[2:0];
			hlo_s1     <= flip_h_i[2:0];
			code_hi_s2 <= vram_q_o[7:4];
			col_s2     <= hlo_s1[1:0];
		end
	end

	// ==================================================
	// stage 2, character rom
	// ==================================================
	// bank, code hi, row, code lo, half of the 8 pixel row
	assign char_addr = {char_bank_i, vram_q_o[7:4], row_s1, vram_q_o[3:0], hlo_s1[2]};

	rom_table #(
		.BASE  (DN_CHAR_BASE),
		.DEPTH (DN_CHAR_SIZE)
	) u_char_rom (
		.clk2_6MHZ (clk2_6MHZ),
		.dn_addr_i (dn_addr_i),
		.dn_data_i (dn_data_i),
		.dn_wr_i   (dn_wr_i),
		.rd_addr_i (char_addr),
		.q_o       (char_q)
	);

	// ==================================================
	// stage 3, bit select and fg prom
	// ==================================================
	assign pix     = {char_q[4 + col_s2], char_q[col_s2]};   // two planes per nibble
	assign fg_addr = {pal_a7_i, pal_a6_i, pix, code_hi_s2};

	rom_table #(
		.BASE  (DN_FGPROM_BASE),
		.DEPTH (DN_FGPROM_SIZE)
	) u_fg_prom (
		.clk2_6MHZ (clk2_6MHZ),
		.dn_addr_i (dn_addr_i),
		.dn_data_i (dn_data_i),
		.dn_wr_i   (dn_wr_i),
		.rd_addr_i (fg_addr),
		.q_o       (fg_q)
	);

	assign fg_idx_o = fg_q[3:0];   // upper nibble unused on the board

endmodule

//--- design/layer_mixer.sv
// layer priority mixer and colour prom
`timescale 1ns/1ps

module layer_mixer (
	input  logic                    clk2_6MHZ,
	input  logic                    RAMB,
	input  exerion_pkg::color_idx_t fg_idx_i,
	input  exerion_pkg::color_idx_t sprite_idx_i,
	input  exerion_pkg::color_idx_t bg_idx_i,
	input  logic                    hblank_i,
	input  logic                    vblank_i,
	input  exerion_pkg::dn_addr_t   dn_addr_i,
	input  exerion_pkg::byte_t      dn_data_i,
	input  logic                    dn_wr_i,
	output exerion_pkg::rgb_t       rgb_o
);
	import exerion_pkg::*;

	pal_addr_t  pal_addr;
	byte_t      col_q;
	logic [1:0] live_q;   // mute until pipe has filled

	// fg over sprites over background, upper half of prom for fg and sprites
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB)
			pal_addr <= '0;
		else if (hblank_i || vblank_i)
			pal_addr <= '0;
		else if (fg_idx_i != '0)
			pal_addr <= {1'b1, fg_idx_i};
		else if (sprite_idx_i != '0)
			pal_addr <= {1'b1, sprite_idx_i};
		else
			pal_addr <= {1'b0, bg_idx_i};   // bg 0 lands on entry 0
	end

	rom_table #(
		.BASE  (DN_COLPROM_BASE),
		.DEPTH (DN_COLPROM_SIZE)
	) u_col_prom (
		.clk2_6MHZ (clk2_6MHZ),
		.dn_addr_i (dn_addr_i),
		.dn_data_i (dn_data_i),
		.dn_wr_i   (dn_wr_i),
		.rd_addr_i (pal_addr),
		.q_o       (col_q)
	);

	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB)
			live_q <= '0;
		else
			live_q <= {live_q[0], 1'b1};
	end

	assign rgb_o = live_q[1] ? rgb_t'(col_q) : '0;   // bbgggrrr

endmodule

//--- design/exerion_video.sv
// exerion video core top
`timescale 1ns/1ps

module exerion_video (
	input  logic                    clk2_6MHZ,
	input  logic                    RAMB,
	input  exerion_pkg::cpu_addr_t  bus_addr_i,
	input  exerion_pkg::byte_t      bus_wdata_i,
	input  logic                    bus_wr_i,
	input  logic                    bus_rd_i,
	input  exerion_pkg::byte_t      controls_i,
	input  exerion_pkg::byte_t      dip1_i,
	input  exerion_pkg::byte_t      dip2_i,
	input  exerion_pkg::color_idx_t sprite_idx_i,
	input  exerion_pkg::color_idx_t bg_idx_i,
	input  exerion_pkg::dn_addr_t   dn_addr_i,
	input  exerion_pkg::byte_t      dn_data_i,
	input  logic                    dn_wr_i,
	output exerion_pkg::byte_t      bus_rdata_o,
	output exerion_pkg::rgb_t       rgb_o,
	output logic                    hsync_o,
	output logic                    vsync_o,
	output logic                    hblank_o,
	output logic                    vblank_o
);
	import exerion_pkg::*;

	pix_h_t     flip_h;
	pix_v_t     flip_v;
	logic       vblank_raw;
	logic       hblank_s3;
	logic       vblank_s3;
	logic       vram_cs;
	logic       vram_we;
	vram_addr_t vram_addr;
	byte_t      vram_wdata;
	byte_t      vram_q;
	logic       flip;
	logic       pal_a6;
	logic       pal_a7;
	logic       char_bank;
	color_idx_t fg_idx;

	video_timing u_timing (
		.clk2_6MHZ (clk2_6MHZ), .RAMB (RAMB), .flip_i (flip),
		.flip_h_o (flip_h), .flip_v_o (flip_v), .vblank_raw_o (vblank_raw),
		.hblank_s3_o (hblank_s3), .vblank_s3_o (vblank_s3),
		.hsync_o (hsync_o), .vsync_o (vsync_o),
		.hblank_o (hblank_o), .vblank_o (vblank_o)
	);

	cpu_bus_port u_bus (
		.clk2_6MHZ (clk2_6MHZ), .RAMB (RAMB),
		.bus_addr_i (bus_addr_i), .bus_wdata_i (bus_wdata_i),
		.bus_wr_i (bus_wr_i), .bus_rd_i (bus_rd_i),
		.controls_i (controls_i), .dip1_i (dip1_i), .dip2_i (dip2_i),
		.vblank_i (vblank_raw), .vram_q_i (vram_q), .bus_rdata_o (bus_rdata_o),
		.vram_cs_o (vram_cs), .vram_we_o (vram_we),
		.vram_addr_o (vram_addr), .vram_wdata_o (vram_wdata),
		.flip_o (flip), .pal_a6_o (pal_a6), .pal_a7_o (pal_a7),
		.char_bank_o (char_bank)
	);

	tile_layer u_fg (
		.clk2_6MHZ (clk2_6MHZ), .RAMB (RAMB),
		.flip_h_i (flip_h), .flip_v_i (flip_v),
		.vram_cs_i (vram_cs), .vram_we_i (vram_we),
		.vram_addr_i (vram_addr), .vram_wdata_i (vram_wdata),
		.pal_a6_i (pal_a6), .pal_a7_i (pal_a7), .char_bank_i (char_bank),
		.dn_addr_i (dn_addr_i), .dn_data_i (dn_data_i), .dn_wr_i (dn_wr_i),
		.vram_q_o (vram_q), .fg_idx_o (fg_idx)
	);

	// blank taken at stage three to meet the mixer
	layer_mixer u_mix (
		.clk2_6MHZ (clk2_6MHZ), .RAMB (RAMB),
		.fg_idx_i (fg_idx), .sprite_idx_i (sprite_idx_i), .bg_idx_i (bg_idx_i),
		.hblank_i (hblank_s3), .vblank_i (vblank_s3),
		.dn_addr_i (dn_addr_i), .dn_data_i (dn_data_i), .dn_wr_i (dn_wr_i),
		.rgb_o (rgb_o)
	);

endmodule

//--- test/tb_tasks.svh
// testbench helper tasks
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

	// ==================================================
	// reporting
	// ==================================================
	task automatic abort_run(input string why);
		err_cnt++;
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped");
	endtask

	// single compare point for every check
	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			abort_run($sformatf("mismatch at %0t: %s expected %0h, actual %0h",
				$time, name, exp, act));
	endtask

	function automatic logic raster_bit(input int sel);
		case (sel)
			0:       return hsync;
			1:       return vsync;
			2:       return hblank;
			default: return vblank;
		endcase
	endfunction

	// returns on the falling clock edge where the output first shows level
	task automatic wait_edge(input int sel, input logic level, input int limit, input string what);
		int   n = 0;
		logic prev;
		logic hit = 1'b0;
		@(negedge clk2_6MHZ);
		prev = raster_bit(sel);
		while (!hit) begin
			@(negedge clk2_6MHZ);
			n++;
			if (n > limit)
				abort_run($sformatf("timeout: no %s within %0d clocks", what, limit));
			hit  = (prev != level) && (raster_bit(sel) == level);
			prev = raster_bit(sel);
		end
	endtask

	// ==================================================
	// download and bus drivers
	// ==================================================
	// back to back download writes, ramp adds the offset to the byte
	task automatic dn_fill(input logic [31:0] base, input logic [31:0] data,
			input logic [31:0] count, input logic ramp);
		for (int i = 0; i < int'(count); i++) begin
			@(posedge clk2_6MHZ);
			dn_wr   <= 1'b1;
			dn_addr <= 16'(base + i);
			dn_data <= ramp ? 8'(data + i) : data[7:0];
		end
		@(posedge clk2_6MHZ);
		dn_wr <= 1'b0;
	endtask

	task automatic bus_fill(input logic [31:0] base, input logic [31:0] data,
			input logic [31:0] count);
		for (int i = 0; i < int'(count); i++) begin
			@(posedge clk2_6MHZ);
			bus_wr    <= 1'b1;   // one clock pulse per write
			bus_addr  <= 16'(base + i);
			bus_wdata <= data[7:0];
			@(posedge clk2_6MHZ);
			bus_wr <= 1'b0;
		end
	endtask

	task automatic bus_read_check(input logic [31:0] addr, input logic [31:0] exp_raw);
		logic        vb;
		logic [31:0] exp = exp_raw;
		// start of active video, well clear of the line where vblank moves
		wait_edge(2, 1'b0, 2 * LINE_CLKS, "hblank_o falling edge");
		@(posedge clk2_6MHZ);
		bus_addr <= addr[15:0];
		bus_rd   <= 1'b1;
		@(negedge clk2_6MHZ);
		vb = vblank;   // level seen by the strobe
		@(posedge clk2_6MHZ);
		bus_rd <= 1'b0;
		@(posedge clk2_6MHZ);
		@(negedge clk2_6MHZ);
		if (addr[15:11] == IN3_ADDR[15:11])
			exp[0] = vb;   // status bit 0 is vblank
		check_eq("bus_rdata_o", exp, {24'h0, bus_rdata});
	endtask

`endif

//--- test/tb_exerion_video.sv
// exerion video testbench
`timescale 1ns/1ps

module tb_exerion_video;
	import exerion_pkg::*;

	localparam int LINE_CLKS  = 424;
	localparam int FRAME_CLKS = 424 * 256;
	localparam int VIS_PIX    = 322;   // active clocks per line
	localparam int STIM_RECS  = 64;

	logic        clk2_6MHZ;
	logic        RAMB;
	cpu_addr_t   bus_addr;
	byte_t       bus_wdata;
	logic        bus_wr;
	logic        bus_rd;
	byte_t       controls;
	byte_t       dip1;
	byte_t       dip2;
	color_idx_t  sprite_idx;
	color_idx_t  bg_idx;
	dn_addr_t    dn_addr;
	byte_t       dn_data;
	logic        dn_wr;
	byte_t       bus_rdata;
	rgb_t        rgb;
	logic        hsync;
	logic        vsync;
	logic        hblank;
	logic        vblank;
	logic [31:0] stim [4*STIM_RECS];   // kind, addr, data, aux
	int          err_cnt;
	int          rec;

	initial clk2_6MHZ = 1'b0;
	always #2 clk2_6MHZ = ~clk2_6MHZ;   // 4 ns period

	exerion_video dut_i (
		.clk2_6MHZ (clk2_6MHZ), .RAMB (RAMB),
		.bus_addr_i (bus_addr), .bus_wdata_i (bus_wdata),
		.bus_wr_i (bus_wr), .bus_rd_i (bus_rd),
		.controls_i (controls), .dip1_i (dip1), .dip2_i (dip2),
		.sprite_idx_i (sprite_idx), .bg_idx_i (bg_idx),
		.dn_addr_i (dn_addr), .dn_data_i (dn_data), .dn_wr_i (dn_wr),
		.bus_rdata_o (bus_rdata), .rgb_o (rgb),
		.hsync_o (hsync), .vsync_o (vsync), .hblank_o (hblank), .vblank_o (vblank)
	);

	`include "tb_tasks.svh"

	// ==================================================
	// raster checks
	// ==================================================
	task automatic check_line_timing();
		int   clks = 0;
		int   hs_hi = 0;
		int   vis = 0;
		logic prev = 1'b1;
		logic done = 1'b0;
		wait_edge(0, 1'b1, 2 * LINE_CLKS, "hsync_o rising edge");
		while (!done) begin
			if (hsync)
				hs_hi++;
			if (!hblank)
				vis++;
			@(negedge clk2_6MHZ);
			clks++;
			done = hsync && !prev;   // next rise
			prev = hsync;
			if (clks > 2 * LINE_CLKS)
				abort_run("timeout: second hsync_o rising edge never came");
		end
		check_eq("line clocks", LINE_CLKS, clks);
		check_eq("hsync_o high clocks", 16, hs_hi);
		check_eq("hblank_o low clocks", VIS_PIX, vis);
	endtask

	task automatic check_frame_timing();
		int   clks = 0;
		int   lines = 0;
		int   vis_lines = 0;
		int   vs_lines = 0;
		logic hs_prev = 1'b0;
		logic vs_prev = 1'b0;
		logic done = 1'b0;
		wait_edge(1, 1'b0, 2 * FRAME_CLKS, "vsync_o falling edge");
		while (!done) begin
			if (hsync && !hs_prev) begin
				lines++;   // one line per hsync rise
				if (!vblank)
					vis_lines++;
				if (!vsync)
					vs_lines++;
			end
			hs_prev = hsync;
			@(negedge clk2_6MHZ);
			clks++;
			done    = vs_prev && !vsync;
			vs_prev = vsync;
			if (clks > 2 * FRAME_CLKS)
				abort_run("timeout: second vsync_o falling edge never came");
		end
		check_eq("frame clocks", FRAME_CLKS, clks);
		check_eq("lines per frame", 256, lines);
		check_eq("vblank_o low lines", 224, vis_lines);
		check_eq("vsync_o low lines", 4, vs_lines);
	endtask

	// ==================================================
	// colour checks
	// ==================================================
	// one full frame from vsync, every sample classed by the aligned blanks
	task automatic check_frame_colour(input logic [31:0] vis_exp, input logic [31:0] blank_exp);
		int vis = 0;
		wait_edge(1, 1'b0, 2 * FRAME_CLKS, "vsync_o falling edge");
		for (int n = 0; n < FRAME_CLKS; n++) begin
			if (!hblank && !vblank) begin
				vis++;
				check_eq("rgb_o visible", vis_exp, {24'h0, rgb});
			end else begin
				check_eq("rgb_o blanked", blank_exp, {24'h0, rgb});
			end
			@(negedge clk2_6MHZ);
		end
		check_eq("visible samples", 224 * VIS_PIX, vis);
	endtask

	task automatic check_first_line(input logic [31:0] exp);
		int vis = 0;
		wait_edge(3, 1'b0, 2 * FRAME_CLKS, "vblank_o falling edge");
		for (int n = 0; n < LINE_CLKS; n++) begin
			if (!hblank && !vblank) begin
				vis++;
				check_eq("rgb_o first line", exp, {24'h0, rgb});
			end
			@(negedge clk2_6MHZ);
		end
		check_eq("first line pixels", VIS_PIX, vis);
	endtask

	task automatic run_record(input logic [31:0] kind, input logic [31:0] a,
			input logic [31:0] d, input logic [31:0] x);
		case (kind)
			32'h1: dn_fill(a, d, x, 1'b0);
			32'h2: dn_fill(a, d, x, 1'b1);
			32'h3: bus_fill(a, d, x);
			32'h4: bus_read_check(a, x);
			32'h5: begin
				@(posedge clk2_6MHZ);
				controls <= a[15:8];
				dip1     <= a[7:0];
				dip2     <= d[7:0];
			end
			32'h6: begin
				@(posedge clk2_6MHZ);
				sprite_idx <= a[7:4];
				bg_idx     <= a[3:0];
				check_frame_colour(d, x);
			end
			32'h7:   check_first_line(d);
			default: abort_run($sformatf("unknown stimulus kind %0h in record %0d", kind, rec));
		endcase
	endtask

	initial begin
		RAMB       <= 1'b0;
		bus_addr   <= '0;
		bus_wdata  <= '0;
		bus_wr     <= 1'b0;
		bus_rd     <= 1'b0;
		controls   <= '0;
		dip1       <= '0;
		dip2       <= '0;
		sprite_idx <= '0;
		bg_idx     <= '0;
		dn_addr    <= '0;
		dn_data    <= '0;
		dn_wr      <= 1'b0;
		err_cnt = 0;
		rec     = 0;
		$readmemh("test/video_stimulus.txt", stim);

		// reset values, checked while RAMB is still low
		repeat (9) @(posedge clk2_6MHZ);
		@(negedge clk2_6MHZ);
		check_eq("hsync_o", 32'd0, 32'(hsync));
		check_eq("vsync_o", 32'd1, 32'(vsync));
		check_eq("hblank_o", 32'd1, 32'(hblank));
		check_eq("vblank_o", 32'd1, 32'(vblank));
		check_eq("rgb_o", 32'd0, {24'h0, rgb});
		check_eq("bus_rdata_o", 32'd0, {24'h0, bus_rdata});
		@(posedge clk2_6MHZ);
		RAMB <= 1'b1;

		check_line_timing();
		check_frame_timing();

		while (rec < STIM_RECS && stim[4*rec] != 32'h0) begin
			run_record(stim[4*rec], stim[4*rec+1], stim[4*rec+2], stim[4*rec+3]);
			rec++;
		end
		if (rec == 0)
			abort_run("stimulus file held no records");

		if (err_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- test/video_stimulus.txt
// columns: kind addr data aux, all hex, aux is a count or an expected value
// kinds: 1 dn fill, 2 dn ramp, 3 bus write run, 4 bus read, 5 ports, 6 frame, 7 first line
5 3CA5 06 0000
4 A000 00 003C
4 A7FF 00 003C
4 A800 00 00A5
4 B000 00 000A
4 9000 00 0000
4 E000 00 0000
1 0000 FF 2000
1 2000 00 0100
1 2031 05 0001
1 2032 09 0001
2 2100 40 0020
3 8000 10 0800
4 8000 00 0010
4 87FF 00 0010
3 8123 5A 0001
4 8123 00 005A
3 8123 10 0001
6 0000 55 0040
1 0000 00 2000
6 0037 53 0040
6 0007 47 0040
1 0000 FF 2000
3 8400 20 0400
7 0000 55 0000
3 C000 01 0001
7 0000 59 0000
0 0000 00 0000

//--- sim.f
+incdir+test
design/exerion_pkg.sv
design/video_timing.sv
design/cpu_bus_port.sv
design/rom_table.sv
design/tile_layer.sv
design/layer_mixer.sv
design/exerion_video.sv
test/tb_exerion_video.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the exerion video testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_exerion_video -f sim.f -o tb_exerion_video \
	&& ./obj_dir/tb_exerion_video | tee /dev/stderr | grep -q -F -- '** PASS **' \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
